// File: hw/rap_pkg.sv
/*
 * Shared definitions for the return address predictor
 * Major opcodes of the control-flow instruction groups
 * Link register numbers used by the return stack hints
 * Control-flow kind and stack operation enums
 */

`default_nettype none

package rap_pkg;

  ////////////////////////////////////////
  // Major opcodes, instr[6:0]
  ////////////////////////////////////////

  // Unconditional jump with 20-bit offset
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  // Register-indirect jump
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  // Conditional branches, all funct3 values
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

  ////////////////////////////////////////
  // Link registers
  ////////////////////////////////////////

  // Standard return address
  localparam logic [4:0] REG_RA = 5'd1;
  // Alternate link register
  localparam logic [4:0] REG_T0 = 5'd5;

  // Decoded control-flow kind of one instruction
  typedef enum logic [1:0] {
    KIND_SEQ    = 2'd0,
    KIND_JAL    = 2'd1,
    KIND_JALR   = 2'd2,
    KIND_BRANCH = 2'd3
  } cf_kind_e;

  // Stack operation requested by one instruction
  typedef enum logic [1:0] {
    RSB_NONE     = 2'd0,
    RSB_PUSH     = 2'd1,
    RSB_POP      = 2'd2,
    RSB_POP_PUSH = 2'd3
  } rsb_op_e;

endpackage

`default_nettype wire

// File: hw/link_hint_decoder.sv
/*
 * Control-flow decoder for the return address predictor
 * Classifies an instruction as sequential, JAL, JALR or branch
 * Derives the return stack operation from the rd/rs1 link hints
 */

`default_nettype none

module link_hint_decoder
  import rap_pkg::*;
(
  input  logic [31:0] instr_i,
  output cf_kind_e    kind_o,
  output rsb_op_e     rsb_op_o
);

  ////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////

  logic [6:0] opcode;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic       rd_link;
  logic       rs1_link;
  logic       same_reg;

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];

  // Only x1 and x5 act as link registers
  assign rd_link  = (rd == REG_RA) || (rd == REG_T0);
  assign rs1_link = (rs1 == REG_RA) || (rs1 == REG_T0);
  assign same_reg = (rs1 == rd);

  ////////////////////////////////////////
  // Kind decode
  ////////////////////////////////////////

  always_comb begin
    unique case (opcode)
      OPC_JAL:    kind_o = KIND_JAL;
      OPC_JALR:   kind_o = KIND_JALR;
      OPC_BRANCH: kind_o = KIND_BRANCH;
      default:    kind_o = KIND_SEQ;
    endcase
  end

  ////////////////////////////////////////
  // Stack operation from link hints
  ////////////////////////////////////////

  always_comb begin
    rsb_op_o = RSB_NONE;
    unique case (kind_o)
      // JAL has no rs1, a link rd marks a call
      KIND_JAL: begin
        if (rd_link) begin
          rsb_op_o = RSB_PUSH;
        end
      end
      KIND_JALR: begin
        unique case ({rd_link, rs1_link})
          // Plain indirect jump
          2'b00: rsb_op_o = RSB_NONE;
          // Return
          2'b01: rsb_op_o = RSB_POP;
          // Call through a register
          2'b10: rsb_op_o = RSB_PUSH;
          // Coroutine swap unless both name the same register
          2'b11: rsb_op_o = same_reg ? RSB_PUSH : RSB_POP_PUSH;
          default: rsb_op_o = RSB_NONE;
        endcase
      end
      // Branches and everything else never touch the stack
      default: rsb_op_o = RSB_NONE;
    endcase
  end

  // No stack traffic for sequential code or branches
  always_comb begin
    assert final ((kind_o != KIND_SEQ && kind_o != KIND_BRANCH) || rsb_op_o == RSB_NONE)
      else $error("stack operation decoded for a non-jump instruction");
  end

endmodule

`default_nettype wire

// File: hw/jump_target_unit.sv
/*
 * Target address unit
 * Sign-extends the J-type and B-type immediates
 * Computes PC+4, the JAL target and the branch target
 */

`default_nettype none

module jump_target_unit #(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0] pc_i,
  input  logic [31:0]     instr_i,
  output logic [XLEN-1:0] seq_pc_o,
  output logic [XLEN-1:0] jal_target_o,
  output logic [XLEN-1:0] br_target_o,
  output logic            br_backward_o
);

  ////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////

  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_b;

  // J-type, imm[20|10:1|11|19:12], bit 0 always zero
  assign imm_j = {{(XLEN-20){instr_i[31]}},
                  instr_i[19:12],
                  instr_i[20],
                  instr_i[30:21],
                  1'b0};

  // B-type, imm[12|10:5] and imm[4:1|11], bit 0 always zero
  assign imm_b = {{(XLEN-12){instr_i[31]}},
                  instr_i[7],
                  instr_i[30:25],
                  instr_i[11:8],
                  1'b0};

  ////////////////////////////////////////
  // Target adders
  ////////////////////////////////////////

  // Uncompressed only, so fall-through is always +4
  assign seq_pc_o     = pc_i + XLEN'(4);
  assign jal_target_o = pc_i + imm_j;
  assign br_target_o  = pc_i + imm_b;

  // Negative offset means a loop back edge
  assign br_backward_o = instr_i[31];

endmodule

`default_nettype wire

// File: hw/return_stack.sv
/*
 * Return stack buffer
 * Shifting entry array with entry 0 as the top of stack
 * Saturating fill count, oldest entry dropped on overflow
 * Last pushed value returned while the stack is empty
 */

`default_nettype none

module return_stack #(
  parameter int XLEN  = 32,
  parameter int DEPTH = 4
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            push_i,
  input  logic            pop_i,
  input  logic [XLEN-1:0] d_i,
  output logic [XLEN-1:0] q_o,
  output logic            empty_o
);

  // Count runs from 0 up to and including DEPTH
  localparam int CNT_W = $clog2(DEPTH + 1);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  logic [XLEN-1:0]  entries [DEPTH];
  logic [XLEN-1:0]  last_push_q;
  logic [CNT_W-1:0] cnt_q;

  // Entry array shifts with every stack operation
  always_ff @(posedge clk_i) begin
    unique case ({push_i, pop_i})
      // Push shifts down and writes the new top
      2'b10: begin
        for (int n = DEPTH - 1; n > 0; n--) begin
          entries[n] <= entries[n-1];
        end
        entries[0] <= d_i;
      end
      // Pop shifts up and the bottom entry keeps its old value
      2'b01: begin
        for (int n = 0; n < DEPTH - 1; n++) begin
          entries[n] <= entries[n+1];
        end
      end
      // Pop then push collapses to replacing the top
      2'b11: entries[0] <= d_i;
      default: ;
    endcase
  end

  // Fallback value for an empty stack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_push_q <= '0;
    end else if (push_i) begin
      last_push_q <= d_i;
    end
  end

  ////////////////////////////////////////
  // Fill count
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      unique case ({push_i, pop_i})
        // Saturates at DEPTH and the oldest entry is lost
        2'b10: if (cnt_q != CNT_W'(DEPTH)) cnt_q <= cnt_q + 1'b1;
        // Underflow keeps the stack empty
        2'b01: if (cnt_q != '0) cnt_q <= cnt_q - 1'b1;
        // Pop-push on empty leaves exactly one entry
        2'b11: if (cnt_q == '0) cnt_q <= CNT_W'(1);
        default: ;
      endcase
    end
  end

  assign empty_o = (cnt_q == '0);
  assign q_o     = empty_o ? last_push_q : entries[0];

  // Count stays within the array
  assert property (@(posedge clk_i) disable iff (!rst_ni) cnt_q <= CNT_W'(DEPTH))
    else $error("return stack count exceeds DEPTH");

endmodule

`default_nettype wire

// File: hw/next_pc_ctrl.sv
/*
 * Next PC control
 * Selects the predicted next PC from the decoded kind
 * Drives the return stack strobes and registers the prediction
 */

`default_nettype none

module next_pc_ctrl
  import rap_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            valid_i,
  input  cf_kind_e        kind_i,
  input  rsb_op_e         rsb_op_i,
  input  logic [XLEN-1:0] seq_pc_i,
  input  logic [XLEN-1:0] jal_target_i,
  input  logic [XLEN-1:0] br_target_i,
  input  logic            br_backward_i,
  input  logic [XLEN-1:0] rsb_top_i,
  input  logic            rsb_empty_i,
  output logic            rsb_push_o,
  output logic            rsb_pop_o,
  output logic [XLEN-1:0] rsb_data_o,
  output logic [XLEN-1:0] npc_o,
  output logic            pred_jump_o,
  output logic            pred_valid_o
);

  logic [XLEN-1:0] npc_d;
  logic            jump_d;
  logic            op_push;
  logic            op_pop;

  // Split the op into its push and pop halves
  assign op_push = (rsb_op_i == RSB_PUSH) || (rsb_op_i == RSB_POP_PUSH);
  assign op_pop  = (rsb_op_i == RSB_POP)  || (rsb_op_i == RSB_POP_PUSH);

  ////////////////////////////////////////
  // Next PC selection
  ////////////////////////////////////////

  always_comb begin
    // Default is the sequential path
    npc_d  = seq_pc_i;
    jump_d = 1'b0;
    unique case (kind_i)
      KIND_JAL: begin
        npc_d  = jal_target_i;
        jump_d = 1'b1;
      end
      // Static BTFN rule
      KIND_BRANCH: begin
        if (br_backward_i) begin
          npc_d  = br_target_i;
          jump_d = 1'b1;
        end
      end
      // Return prediction reads the top before this update
      KIND_JALR: begin
        if (op_pop && !rsb_empty_i) begin
          npc_d  = rsb_top_i;
          jump_d = 1'b1;
        end
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // Stack strobes
  ////////////////////////////////////////

  // Both high means pop then push
  assign rsb_push_o = valid_i && op_push;
  assign rsb_pop_o  = valid_i && op_pop;
  // Return address is always the fall-through PC
  assign rsb_data_o = seq_pc_i;

  // Prediction register, one cycle after valid_i
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pred_valid_o <= 1'b0;
      npc_o        <= '0;
      pred_jump_o  <= 1'b0;
    end else begin
      pred_valid_o <= valid_i;
      if (valid_i) begin
        npc_o       <= npc_d;
        pred_jump_o <= jump_d;
      end
    end
  end

  // Every fetched instruction yields a prediction on the next cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni) valid_i |=> pred_valid_o)
    else $error("prediction missing one cycle after valid_i");

endmodule

`default_nettype wire

// File: hw/rap_top.sv
/*
 * Return address predictor top level
 * Connects decoder, target unit, return stack and next PC control
 */

`default_nettype none

module rap_top
  import rap_pkg::*;
#(
  parameter int XLEN  = 32,
  parameter int DEPTH = 4
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            valid_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [31:0]     instr_i,
  output logic            pred_valid_o,
  output logic [XLEN-1:0] npc_o,
  output logic            pred_jump_o,
  output logic            rsb_empty_o
);

  ////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////

  // Decode results
  cf_kind_e        kind;
  rsb_op_e         rsb_op;
  // Target addresses
  logic [XLEN-1:0] seq_pc;
  logic [XLEN-1:0] jal_target;
  logic [XLEN-1:0] br_target;
  logic            br_backward;
  // Stack interface
  logic            push;
  logic            pop;
  logic [XLEN-1:0] push_data;
  logic [XLEN-1:0] top;
  logic            empty;

  link_hint_decoder i_decoder (
    .instr_i  (instr_i),
    .kind_o   (kind),
    .rsb_op_o (rsb_op)
  );

  jump_target_unit #(.XLEN(XLEN)) i_targets (
    .pc_i          (pc_i),
    .instr_i       (instr_i),
    .seq_pc_o      (seq_pc),
    .jal_target_o  (jal_target),
    .br_target_o   (br_target),
    .br_backward_o (br_backward)
  );

  return_stack #(.XLEN(XLEN), .DEPTH(DEPTH)) i_rsb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (push),
    .pop_i   (pop),
    .d_i     (push_data),
    .q_o     (top),
    .empty_o (empty)
  );

  next_pc_ctrl #(.XLEN(XLEN)) i_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .valid_i       (valid_i),
    .kind_i        (kind),
    .rsb_op_i      (rsb_op),
    .seq_pc_i      (seq_pc),
    .jal_target_i  (jal_target),
    .br_target_i   (br_target),
    .br_backward_i (br_backward),
    .rsb_top_i     (top),
    .rsb_empty_i   (empty),
    .rsb_push_o    (push),
    .rsb_pop_o     (pop),
    .rsb_data_o    (push_data),
    .npc_o         (npc_o),
    .pred_jump_o   (pred_jump_o),
    .pred_valid_o  (pred_valid_o)
  );

  // Stack level is visible outside
  assign rsb_empty_o = empty;

endmodule

`default_nettype wire

// File: tests/tb_rap.sv
/*
 * Testbench for the return address predictor
 * LFSR-driven instruction stream with call and return bursts
 * Reference model of the prediction rules and the return stack
 * Per-cycle checks of the prediction and the stack level, plus a watchdog
 */

`default_nettype none

module tb_rap
  import rap_pkg::*;
();

  localparam int XLEN        = 32;
  localparam int DEPTH       = 4;
  localparam int NUM_INSTR   = 2000;
  localparam int MAX_GAP     = 3;
  localparam int CLK_PERIOD  = 20;
  localparam int DRIVE_DELAY = 2;
  // Every instruction takes at most MAX_GAP idle cycles plus its own
  localparam int TIMEOUT     = (NUM_INSTR * (MAX_GAP + 1) + 50) * CLK_PERIOD;

  logic            clk_i;
  logic            rst_ni;
  logic            valid_i;
  logic [XLEN-1:0] pc_i;
  logic [31:0]     instr_i;
  logic            pred_valid_o;
  logic [XLEN-1:0] npc_o;
  logic            pred_jump_o;
  logic            rsb_empty_o;

  // Model state, entry 0 of the queue is the top of stack
  logic [XLEN-1:0] model_q [$];
  logic [XLEN-1:0] model_last;
  logic [31:0]     lfsr_q;
  // Expected prediction for the next cycle
  logic            exp_valid;
  logic [XLEN-1:0] exp_npc;
  logic            exp_jump;

  rap_top #(.XLEN(XLEN), .DEPTH(DEPTH)) i_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_i      (valid_i),
    .pc_i         (pc_i),
    .instr_i      (instr_i),
    .pred_valid_o (pred_valid_o),
    .npc_o        (npc_o),
    .pred_jump_o  (pred_jump_o),
    .rsb_empty_o  (rsb_empty_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Half of the picks are x1 or x5
  task automatic pick_reg(output logic [4:0] r);
    logic [31:0] sel;
    logic [31:0] raw;
    draw_bits(2, sel);
    draw_bits(5, raw);
    case (sel[1:0])
      2'd0:    r = REG_RA;
      2'd1:    r = REG_T0;
      default: r = raw[4:0];
    endcase
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic make_instr(input int idx, output logic [31:0] ins);
    logic [31:0] sel;
    logic [31:0] f;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    draw_bits(3, sel);
    draw_bits(32, f);
    pick_reg(rd);
    pick_reg(rs1);
    // Call bursts overflow the stack, return bursts drain it past empty
    case ((idx / 40) % 4)
      1: begin
        rd  = f[0] ? REG_RA : REG_T0;
        sel = sel[0] ? 32'd0 : 32'd2;
      end
      3: begin
        rd  = 5'd0;
        rs1 = f[1] ? REG_RA : REG_T0;
        sel = 32'd2;
      end
      default: ;
    endcase
    // Kind mix biased towards jumps and branches
    case (sel[2:0])
      3'd0, 3'd1:       ins = {f[31:12], rd, OPC_JAL};
      3'd2, 3'd3, 3'd4: ins = {f[31:20], rs1, 3'b000, rd, OPC_JALR};
      3'd5, 3'd6:       ins = {f[31:7], OPC_BRANCH};
      default:          ins = {f[31:7], 7'b001_0011};
    endcase
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  task automatic predict(input logic [XLEN-1:0] pc, input logic [31:0] ins);
    logic signed [20:0] off_j;
    logic signed [12:0] off_b;
    logic [XLEN-1:0]    seq;
    logic               rd_l;
    logic               rs1_l;
    logic               do_push;
    logic               do_pop;
    off_j   = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    off_b   = {ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    seq     = pc + XLEN'(4);
    rd_l    = (ins[11:7] == 5'd1) || (ins[11:7] == 5'd5);
    rs1_l   = (ins[19:15] == 5'd1) || (ins[19:15] == 5'd5);
    do_push = 1'b0;
    do_pop  = 1'b0;
    exp_npc  = seq;
    exp_jump = 1'b0;
    if (ins[6:0] == OPC_JAL) begin
      exp_npc  = pc + XLEN'(off_j);
      exp_jump = 1'b1;
      do_push  = rd_l;
    end else if (ins[6:0] == OPC_BRANCH) begin
      // Backward taken, forward not taken
      if (off_b < 0) begin
        exp_npc  = pc + XLEN'(off_b);
        exp_jump = 1'b1;
      end
    end else if (ins[6:0] == OPC_JALR) begin
      // Same link register in rd and rs1 is a push only
      do_pop  = rs1_l && !(rd_l && ins[11:7] == ins[19:15]);
      do_push = rd_l;
      if (do_pop && model_q.size() > 0) begin
        exp_npc  = model_q[0];
        exp_jump = 1'b1;
      end
    end
    // Stack update after the prediction
    if (do_pop && do_push) begin
      if (model_q.size() == 0) begin
        model_q.push_front(seq);
      end else begin
        model_q[0] = seq;
      end
    end else if (do_push) begin
      model_q.push_front(seq);
      if (model_q.size() > DEPTH) begin
        void'(model_q.pop_back());
      end
    end else if (do_pop && model_q.size() > 0) begin
      void'(model_q.pop_front());
    end
    if (do_push) begin
      model_last = seq;
    end
  endtask

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] ins;
    logic [31:0] r;
    int          sent;
    int          gap;
    lfsr_q     = 32'h7af7_9833;
    rst_ni     = 1'b0;
    valid_i    = 1'b0;
    pc_i       = '0;
    instr_i    = '0;
    model_last = '0;
    exp_valid  = 1'b0;
    exp_npc    = '0;
    exp_jump   = 1'b0;
    sent       = 0;
    gap        = 0;
    repeat (3) @(posedge clk_i);
    #(DRIVE_DELAY);
    rst_ni = 1'b1;
    // Idle state straight after reset
    check_value("rsb_empty_o", XLEN'(rsb_empty_o), XLEN'(1));
    check_value("pred_valid_o", XLEN'(pred_valid_o), XLEN'(0));
    while (sent < NUM_INSTR || exp_valid) begin
      @(posedge clk_i);
      #(DRIVE_DELAY);
      // Outputs registered at this edge are stable here
      check_value("pred_valid_o", XLEN'(pred_valid_o), XLEN'(exp_valid));
      if (exp_valid) begin
        check_value("npc_o", npc_o, exp_npc);
        check_value("pred_jump_o", XLEN'(pred_jump_o), XLEN'(exp_jump));
      end
      check_value("rsb_empty_o", XLEN'(rsb_empty_o), XLEN'(model_q.size() == 0));
      exp_valid = 1'b0;
      valid_i   = 1'b0;
      if (sent < NUM_INSTR) begin
        if (gap > 0) begin
          gap--;
        end else begin
          make_instr(sent, ins);
          draw_bits(32, r);
          valid_i = 1'b1;
          pc_i    = {r[31:2], 2'b00};
          instr_i = ins;
          predict(pc_i, ins);
          exp_valid = 1'b1;
          sent++;
          draw_bits(2, r);
          gap = int'(r[1:0]);
        end
      end
    end
    $display("Everything OK");
    $finish;
  end

  // Bounded run time
  initial begin
    #(TIMEOUT);
    $display("Watchdog expired before all predictions were checked");
    $display("Something failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

// File: files.f
hw/rap_pkg.sv
hw/link_hint_decoder.sv
hw/jump_target_unit.sv
hw/return_stack.sv
hw/next_pc_ctrl.sv
hw/rap_top.sv
tests/tb_rap.sv

// File: Makefile
# Verilator build and run for the return address predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_rap
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?=

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: compile
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
